// File: asteroids_update.f
+incdir+include
rtl/asteroids_pkg.sv
rtl/motion_coordinator.sv
rtl/object_store.sv
rtl/object_mover.sv
rtl/collision_checker.sv
rtl/frame_builder.sv
rtl/asteroids_update.sv
sim/asteroids_update_tb.sv

// File: include/asteroids_params.svh
`ifndef ASTEROIDS_PARAMS_SVH
`define ASTEROIDS_PARAMS_SVH

// the grid is 8 by 8, so one coordinate takes three bits
`define GRID_BITS 3
`define N_SHOTS 4
`define N_ASTEROIDS 4
`define SHOT_STEPS 2
`define AST_STEPS 1

// shots sit at words 0 to 3 and asteroids at words 4 to 7
`define ADDR_SHIP 5'd8
`define ADDR_CTRL 5'd9
`define ADDR_SCORE 5'd10
`define ADDR_FRAME 5'd16

`endif

// File: rtl/asteroids_pkg.sv
package asteroids_pkg;
`include "asteroids_params.svh"

    typedef logic [`GRID_BITS-1:0] coord_t;
    typedef logic [1:0] slot_t;
    typedef logic [(1 << `GRID_BITS)-1:0] row_bits_t; // bit x lit

    typedef struct packed {
        logic   active;
        coord_t x;
        coord_t y; // row 0 is the top of the grid
    } game_obj_t;

    typedef struct packed {
        logic      en;
        logic      is_ast; // target is the asteroid bank
        slot_t     slot;
        game_obj_t obj;
    } obj_update_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        logic [4:0] addr;
        logic [7:0] data;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] data;
    } wb_rsp_t;

    typedef enum logic [3:0] {
        st_init,
        st_idle,
        st_clear_counts,
        st_check_shots,
        st_wait_check_shots,
        st_move_shots,
        st_wait_move_shots,
        st_count_shots,
        st_check_ship,
        st_wait_check_ship,
        st_move_asteroids,
        st_wait_move_asteroids,
        st_count_asteroids,
        st_finish,
        st_frame,
        st_wait_frame
    } coord_state_t;

    typedef enum logic {
        mode_shots, // shots against asteroids
        mode_ship   // asteroids against ship and shots
    } checker_mode_t;

endpackage

// File: rtl/asteroids_update.sv
`timescale 1ns/10ps
`include "asteroids_params.svh"

module asteroids_update (
    input  logic                   clock,
    input  logic                   reset,
    input  asteroids_pkg::wb_req_t wb_in,
    output asteroids_pkg::wb_rsp_t wb_out,
    output logic                   update_done
);
    import asteroids_pkg::*;

    game_obj_t [`N_SHOTS-1:0] shots;
    game_obj_t [`N_ASTEROIDS-1:0] asteroids;
    coord_t ship_x;
    obj_update_t shot_upd;
    obj_update_t ast_upd;
    obj_update_t check_upd;
    logic start;
    logic score_inc;
    logic ship_hit_set;
    logic move_start_shots;
    logic move_start_asteroids;
    logic check_start;
    logic frame_start;
    logic move_done_shots;
    logic move_done_asteroids;
    logic check_done;
    logic frame_done;
    checker_mode_t check_mode;
    logic frame_write;
    coord_t frame_row;
    row_bits_t frame_bits;

    motion_coordinator u_coordinator (
        .clock, .reset, .start, .move_done_shots, .move_done_asteroids, .check_done,
        .frame_done, .move_start_shots, .move_start_asteroids, .check_start, .frame_start,
        .update_done, .check_mode
    );

    object_store u_store (
        .clock, .reset, .wb_in, .wb_out, .shot_upd, .ast_upd, .check_upd, .score_inc,
        .ship_hit_set, .update_done, .frame_write, .frame_row, .frame_bits, .shots,
        .asteroids, .ship_x, .start
    );

    object_mover #(.SLOTS(`N_SHOTS), .MOVE_DOWN(1'b0)) u_shot_mover (
        .clock, .reset, .start(move_start_shots), .objects(shots), .upd(shot_upd),
        .done(move_done_shots)
    );

    object_mover #(.SLOTS(`N_ASTEROIDS), .MOVE_DOWN(1'b1)) u_ast_mover (
        .clock, .reset, .start(move_start_asteroids), .objects(asteroids), .upd(ast_upd),
        .done(move_done_asteroids)
    );

    collision_checker u_checker (
        .clock, .reset, .start(check_start), .mode(check_mode), .shots, .asteroids, .ship_x,
        .upd(check_upd), .score_inc, .ship_hit_set, .done(check_done)
    );

    frame_builder u_frame (
        .clock, .reset, .start(frame_start), .shots, .asteroids, .ship_x, .frame_write,
        .frame_row, .frame_bits, .done(frame_done)
    );

endmodule

// File: rtl/collision_checker.sv
`timescale 1ns/10ps
`include "asteroids_params.svh"

module collision_checker (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        start,
    input  asteroids_pkg::checker_mode_t                mode,
    input  asteroids_pkg::game_obj_t [`N_SHOTS-1:0]     shots,
    input  asteroids_pkg::game_obj_t [`N_ASTEROIDS-1:0] asteroids,
    input  asteroids_pkg::coord_t                       ship_x,
    output asteroids_pkg::obj_update_t                  upd,
    output logic                                        score_inc,
    output logic                                        ship_hit_set,
    output logic                                        done
);
    import asteroids_pkg::*;

    logic running;
    logic second; // asteroid removal after its shot was removed
    slot_t idx;
    game_obj_t ast;
    logic shot_hit;
    slot_t shot_slot;
    logic ship_hit;
    logic advance;

    assign ast = asteroids[idx];
    assign ship_hit = (mode == mode_ship) && ast.active && ast.y == '1 && ast.x == ship_x;
    assign advance = running && (second || !shot_hit);

    always_comb begin
        shot_hit = 1'b0;
        shot_slot = '0;
        for (int i = `N_SHOTS - 1; i >= 0; i--) begin // lowest matching slot wins
            if (ast.active && shots[i].active && shots[i].x == ast.x && shots[i].y == ast.y) begin
                shot_hit = 1'b1;
                shot_slot = slot_t'(i);
            end
        end
    end

    always_comb begin
        upd.en = 1'b0;
        upd.is_ast = 1'b1;
        upd.slot = idx;
        upd.obj = '{active: 1'b0, x: ast.x, y: ast.y}; // shot and asteroid share the cell
        score_inc = 1'b0;
        ship_hit_set = 1'b0;
        if (running && second) begin
            upd.en = 1'b1;
        end else if (running && shot_hit) begin
            upd.en = 1'b1;
            upd.is_ast = 1'b0;
            upd.slot = shot_slot;
            score_inc = 1'b1;
        end else if (running && ship_hit) begin
            upd.en = 1'b1;
            ship_hit_set = 1'b1;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            second <= 1'b0;
            idx <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                second <= 1'b0;
                idx <= '0;
            end else if (running) begin
                second <= !second && shot_hit;
                if (advance) begin
                    idx <= idx + 1'b1;
                    if (idx == slot_t'(`N_ASTEROIDS - 1)) begin
                        running <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: rtl/frame_builder.sv
`timescale 1ns/10ps
`include "asteroids_params.svh"

module frame_builder (
    input  logic                                        clock,
    input  logic                                        reset,
    input  logic                                        start,
    input  asteroids_pkg::game_obj_t [`N_SHOTS-1:0]     shots,
    input  asteroids_pkg::game_obj_t [`N_ASTEROIDS-1:0] asteroids,
    input  asteroids_pkg::coord_t                       ship_x,
    output logic                                        frame_write,
    output asteroids_pkg::coord_t                       frame_row,
    output asteroids_pkg::row_bits_t                    frame_bits,
    output logic                                        done
);
    import asteroids_pkg::*;

    logic running;
    coord_t row;

    assign frame_write = running;
    assign frame_row = row;

    always_comb begin
        frame_bits = '0;
        for (int i = 0; i < `N_SHOTS; i++) begin
            if (shots[i].active && shots[i].y == row) begin
                frame_bits[shots[i].x] = 1'b1;
            end
        end
        for (int i = 0; i < `N_ASTEROIDS; i++) begin
            if (asteroids[i].active && asteroids[i].y == row) begin
                frame_bits[asteroids[i].x] = 1'b1;
            end
        end
        if (row == '1) begin
            frame_bits[ship_x] = 1'b1; // ship lives on the bottom row
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            row <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                row <= '0;
            end else if (running) begin
                row <= row + 1'b1;
                if (row == '1) begin
                    running <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/motion_coordinator.sv
`timescale 1ns/10ps
`include "asteroids_params.svh"

module motion_coordinator (
    input  logic                         clock,
    input  logic                         reset,
    input  logic                         start,
    input  logic                         move_done_shots,
    input  logic                         move_done_asteroids,
    input  logic                         check_done,
    input  logic                         frame_done,
    output logic                         move_start_shots,
    output logic                         move_start_asteroids,
    output logic                         check_start,
    output logic                         frame_start,
    output logic                         update_done,
    output asteroids_pkg::checker_mode_t check_mode
);
    import asteroids_pkg::*;

    coord_state_t state;
    coord_state_t state_next;
    logic [$clog2(`SHOT_STEPS + 1)-1:0] shot_count; // shot moves done this tick
    logic [$clog2(`AST_STEPS + 1)-1:0] ast_count;
    logic shots_finished;
    logic asts_finished;

    assign shots_finished = (shot_count == `SHOT_STEPS);
    assign asts_finished = (ast_count == `AST_STEPS);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            shot_count <= '0;
            ast_count <= '0;
        end else begin
            state <= state_next;
            if (state == st_clear_counts) begin
                shot_count <= '0;
                ast_count <= '0;
            end
            if (state == st_count_shots) begin
                shot_count <= shot_count + 1'b1;
            end
            if (state == st_count_asteroids) begin
                ast_count <= ast_count + 1'b1;
            end
        end
    end

    always_comb begin
        case (state)
            st_init:                state_next = st_idle;
            st_idle:                state_next = start ? st_clear_counts : st_idle;
            st_clear_counts:        state_next = st_check_shots;
            st_check_shots:         state_next = st_wait_check_shots;
            st_wait_check_shots:    state_next = !check_done ? st_wait_check_shots :
                                                 shots_finished ? st_check_ship : st_move_shots;
            st_move_shots:          state_next = st_wait_move_shots;
            st_wait_move_shots:     state_next = move_done_shots ? st_count_shots
                                                                 : st_wait_move_shots;
            st_count_shots:         state_next = st_frame;
            st_frame:               state_next = st_wait_frame;
            st_wait_frame:          state_next = frame_done ? st_check_shots : st_wait_frame;
            st_check_ship:          state_next = st_wait_check_ship;
            st_wait_check_ship:     state_next = !check_done ? st_wait_check_ship :
                                                 asts_finished ? st_finish : st_move_asteroids;
            st_move_asteroids:      state_next = st_wait_move_asteroids;
            st_wait_move_asteroids: state_next = move_done_asteroids ? st_count_asteroids
                                                                     : st_wait_move_asteroids;
            st_count_asteroids:     state_next = st_check_ship;
            st_finish:              state_next = st_idle;
            default:                state_next = st_init;
        endcase
    end

    assign check_start = (state == st_check_shots) || (state == st_check_ship);
    assign move_start_shots = (state == st_move_shots);
    assign move_start_asteroids = (state == st_move_asteroids);
    assign frame_start = (state == st_frame);
    assign update_done = (state == st_finish);
    assign check_mode = (state == st_check_ship || state == st_wait_check_ship) ? mode_ship
                                                                                 : mode_shots;

    // only one worker may run at a time, so no done may meet a start or another done
    one_start: assert property (@(posedge clock) disable iff (reset)
        $onehot0({move_start_shots, move_start_asteroids, check_start, frame_start,
                  move_done_shots, move_done_asteroids, check_done, frame_done}));

endmodule

// File: rtl/object_mover.sv
`timescale 1ns/10ps

module object_mover #(
    parameter int SLOTS     = 4,
    parameter bit MOVE_DOWN = 1'b0
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 start,
    input  asteroids_pkg::game_obj_t [SLOTS-1:0] objects,
    output asteroids_pkg::obj_update_t           upd,
    output logic                                 done
);
    import asteroids_pkg::*;

    logic running;
    slot_t idx;
    game_obj_t obj;
    logic at_edge; // the move would take the object off the grid

    assign obj = objects[idx];
    assign at_edge = MOVE_DOWN ? (obj.y == '1) : (obj.y == '0);

    always_comb begin
        upd.en = running && obj.active; // empty slots are skipped
        upd.is_ast = MOVE_DOWN;
        upd.slot = idx;
        upd.obj.active = !at_edge;
        upd.obj.x = obj.x;
        upd.obj.y = MOVE_DOWN ? obj.y + 1'b1 : obj.y - 1'b1;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            running <= 1'b0;
            idx <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                running <= 1'b1;
                idx <= '0;
            end else if (running) begin
                idx <= idx + 1'b1;
                if (idx == slot_t'(SLOTS - 1)) begin
                    running <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

endmodule

// File: rtl/object_store.sv
`timescale 1ns/10ps
`include "asteroids_params.svh"

module object_store (
    input  logic                                        clock,
    input  logic                                        reset,
    input  asteroids_pkg::wb_req_t                      wb_in,
    output asteroids_pkg::wb_rsp_t                      wb_out,
    input  asteroids_pkg::obj_update_t                  shot_upd,
    input  asteroids_pkg::obj_update_t                  ast_upd,
    input  asteroids_pkg::obj_update_t                  check_upd,
    input  logic                                        score_inc,
    input  logic                                        ship_hit_set,
    input  logic                                        update_done,
    input  logic                                        frame_write,
    input  asteroids_pkg::coord_t                       frame_row,
    input  asteroids_pkg::row_bits_t                    frame_bits,
    output asteroids_pkg::game_obj_t [`N_SHOTS-1:0]     shots,
    output asteroids_pkg::game_obj_t [`N_ASTEROIDS-1:0] asteroids,
    output asteroids_pkg::coord_t                       ship_x,
    output logic                                        start
);
    import asteroids_pkg::*;

    row_bits_t [(1 << `GRID_BITS)-1:0] frame;
    logic [7:0] score;
    logic ship_hit; // sticky until the next start
    logic busy;
    logic ack;
    logic [7:0] rd_data;
    logic [7:0] rd_next;
    logic req; // fresh bus cycle, not yet acknowledged
    logic host_write; // host may only change state while idle
    obj_update_t upd;

    assign req = wb_in.cyc && wb_in.stb && !ack;
    assign host_write = req && wb_in.we && !busy;
    assign wb_out.ack = ack;
    assign wb_out.data = rd_data;

    always_comb begin
        upd = ast_upd;
        if (shot_upd.en) begin
            upd = shot_upd;
        end
        if (check_upd.en) begin
            upd = check_upd; // checker wins when two are enabled
        end
    end

    always_comb begin
        rd_next = 8'h00;
        if (wb_in.addr[4:2] == 3'b000) begin
            rd_next = {1'b0, shots[wb_in.addr[1:0]]};
        end else if (wb_in.addr[4:2] == 3'b001) begin
            rd_next = {1'b0, asteroids[wb_in.addr[1:0]]};
        end else if ((wb_in.addr & 5'b11000) == `ADDR_FRAME) begin
            rd_next = frame[wb_in.addr[2:0]];
        end else if (wb_in.addr == `ADDR_SHIP) begin
            rd_next = {5'b0, ship_x};
        end else if (wb_in.addr == `ADDR_CTRL) begin
            rd_next = {6'b0, ship_hit, busy};
        end else if (wb_in.addr == `ADDR_SCORE) begin
            rd_next = score;
        end
    end

    always_ff @(posedge clock) begin
        if (req) begin
            rd_data <= rd_next; // valid together with ack
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
            start <= 1'b0;
            busy <= 1'b0;
            ship_hit <= 1'b0;
            score <= '0;
            ship_x <= '0;
            shots <= '0;
            asteroids <= '0;
            frame <= '0;
        end else begin
            ack <= req;
            start <= 1'b0;
            if (host_write && wb_in.addr[4:2] == 3'b000) begin
                shots[wb_in.addr[1:0]] <= game_obj_t'(wb_in.data[6:0]);
            end
            if (host_write && wb_in.addr[4:2] == 3'b001) begin
                asteroids[wb_in.addr[1:0]] <= game_obj_t'(wb_in.data[6:0]);
            end
            if (host_write && wb_in.addr == `ADDR_SHIP) begin
                ship_x <= wb_in.data[`GRID_BITS-1:0];
            end
            if (host_write && wb_in.addr == `ADDR_SCORE) begin
                score <= wb_in.data;
            end
            if (host_write && wb_in.addr == `ADDR_CTRL && wb_in.data[0]) begin
                score <= '0; // a new tick starts with a clean score
                ship_hit <= 1'b0;
                busy <= 1'b1;
                start <= 1'b1;
            end
            if (upd.en && upd.is_ast) begin
                asteroids[upd.slot] <= upd.obj;
            end
            if (upd.en && !upd.is_ast) begin
                shots[upd.slot] <= upd.obj;
            end
            if (score_inc) begin
                score <= score + 8'd1;
            end
            if (ship_hit_set) begin
                ship_hit <= 1'b1;
            end
            if (frame_write) begin
                frame[frame_row] <= frame_bits;
            end
            if (update_done) begin
                busy <= 1'b0;
            end
        end
    end

    // the update mux above trusts the coordinator to run one worker at a time
    one_update: assert property (@(posedge clock) disable iff (reset)
        $onehot0({shot_upd.en, ast_upd.en, check_upd.en}));

endmodule

// File: sim/asteroids_update_tb.sv
`timescale 1ns/10ps
`include "asteroids_params.svh"

module asteroids_update_tb;
    import asteroids_pkg::*;

    localparam int RANDOM_SCENARIOS = 30;
    localparam int TICKS_PER_SCENARIO = 3;
    localparam int DIRECTED_TICKS = 8;
    localparam int CYCLES_PER_TICK = 200; // loading, one update and the full readback
    localparam int CYCLE_LIMIT =
        (DIRECTED_TICKS + RANDOM_SCENARIOS * TICKS_PER_SCENARIO + 2) * CYCLES_PER_TICK;

    typedef struct packed {
        game_obj_t [`N_SHOTS-1:0]     shots;
        game_obj_t [`N_ASTEROIDS-1:0] asteroids;
        coord_t                       ship_x;
        logic [7:0]                   score;
        logic                         ship_hit;
        row_bits_t [7:0]              frame;
    } game_state_t;

    logic clock;
    logic reset;
    wb_req_t wb_in;
    wb_rsp_t wb_out;
    logic update_done;
    int errors = 0;
    int checks = 0;
    int cycles = 0;
    game_state_t expected; // model state after the last predicted tick

    asteroids_update dut (.clock, .reset, .wb_in, .wb_out, .update_done);

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    always @(posedge clock) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: the run hung, no result after %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    function automatic game_obj_t make_obj(input bit active, input int x, input int y);
        game_obj_t o;
        o.active = active;
        o.x = coord_t'(x);
        o.y = coord_t'(y);
        return o;
    endfunction

    function automatic game_obj_t random_obj(input bit narrow);
        game_obj_t o;
        o.active = ($urandom % 4) != 0; // most slots are in play
        o.x = narrow ? coord_t'($urandom % 4) : coord_t'($urandom % 8);
        o.y = coord_t'($urandom % 8);
        return o;
    endfunction

    // one walk over the asteroid slots, each asteroid takes at most one shot
    function automatic game_state_t resolve_hits(input game_state_t s, input bit ship_mode);
        bit found;
        for (int a = 0; a < `N_ASTEROIDS; a++) begin
            found = 1'b0;
            for (int i = 0; i < `N_SHOTS; i++) begin
                if (!found && s.asteroids[a].active && s.shots[i].active &&
                        s.shots[i].x == s.asteroids[a].x && s.shots[i].y == s.asteroids[a].y) begin
                    s.shots[i].active = 1'b0;
                    s.asteroids[a].active = 1'b0;
                    s.score = s.score + 8'd1;
                    found = 1'b1;
                end
            end
            if (ship_mode && s.asteroids[a].active && s.asteroids[a].y == 3'd7 &&
                    s.asteroids[a].x == s.ship_x) begin
                s.asteroids[a].active = 1'b0; // the ship takes the hit, no score
                s.ship_hit = 1'b1;
            end
        end
        return s;
    endfunction

    function automatic game_state_t move_objects(input game_state_t s, input bit asteroid_kind);
        for (int i = 0; i < `N_SHOTS; i++) begin
            if (!asteroid_kind && s.shots[i].active) begin
                s.shots[i].active = s.shots[i].y != 3'd0;
                s.shots[i].y = s.shots[i].y - 3'd1; // row wraps once the shot is gone
            end
        end
        for (int i = 0; i < `N_ASTEROIDS; i++) begin
            if (asteroid_kind && s.asteroids[i].active) begin
                s.asteroids[i].active = s.asteroids[i].y != 3'd7;
                s.asteroids[i].y = s.asteroids[i].y + 3'd1;
            end
        end
        return s;
    endfunction

    function automatic game_state_t draw_frame(input game_state_t s);
        s.frame = '0;
        for (int i = 0; i < `N_SHOTS; i++) begin
            if (s.shots[i].active) begin
                s.frame[s.shots[i].y][s.shots[i].x] = 1'b1;
            end
        end
        for (int i = 0; i < `N_ASTEROIDS; i++) begin
            if (s.asteroids[i].active) begin
                s.frame[s.asteroids[i].y][s.asteroids[i].x] = 1'b1;
            end
        end
        s.frame[7][s.ship_x] = 1'b1;
        return s;
    endfunction

    // the whole tick in the order the coordinator runs it
    function automatic game_state_t predict_tick(input game_state_t s);
        s.score = 8'd0;
        s.ship_hit = 1'b0;
        for (int n = 0; n < `SHOT_STEPS; n++) begin
            s = resolve_hits(s, 1'b0);
            s = move_objects(s, 1'b0);
            s = draw_frame(s);
        end
        s = resolve_hits(s, 1'b0);
        for (int n = 0; n < `AST_STEPS; n++) begin
            s = resolve_hits(s, 1'b1);
            s = move_objects(s, 1'b1);
        end
        s = resolve_hits(s, 1'b1);
        return s;
    endfunction

    task automatic compare(input logic [7:0] got, input logic [7:0] want, input string what);
        checks++;
        if (got !== want) begin
            errors++;
            $display("FAIL at %0t ns: %s read 0x%02h, expected 0x%02h", $time, what, got, want);
        end
    endtask

    task automatic bus_write(input logic [4:0] addr, input logic [7:0] data);
        @(negedge clock);
        wb_in = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, addr: addr, data: data};
        @(negedge clock);
        while (!wb_out.ack) @(negedge clock);
        wb_in = '0;
    endtask

    task automatic bus_read(input logic [4:0] addr, output logic [7:0] data);
        @(negedge clock);
        wb_in = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, addr: addr, data: 8'h00};
        @(negedge clock);
        while (!wb_out.ack) @(negedge clock);
        data = wb_out.data;
        wb_in = '0;
    endtask

    task automatic load_state(input game_state_t s);
        for (int i = 0; i < `N_SHOTS; i++) begin
            bus_write(5'(i), {1'b0, s.shots[i]});
        end
        for (int i = 0; i < `N_ASTEROIDS; i++) begin
            bus_write(5'(4 + i), {1'b0, s.asteroids[i]});
        end
        bus_write(`ADDR_SHIP, {5'b0, s.ship_x});
    endtask

    task automatic verify_state(input game_state_t s);
        logic [7:0] got;
        for (int i = 0; i < `N_SHOTS; i++) begin
            bus_read(5'(i), got);
            compare(got, {1'b0, s.shots[i]}, $sformatf("shot %0d", i));
        end
        for (int i = 0; i < `N_ASTEROIDS; i++) begin
            bus_read(5'(4 + i), got);
            compare(got, {1'b0, s.asteroids[i]}, $sformatf("asteroid %0d", i));
        end
        bus_read(`ADDR_SHIP, got);
        compare(got, {5'b0, s.ship_x}, "ship");
        bus_read(`ADDR_CTRL, got);
        compare(got, {6'b0, s.ship_hit, 1'b0}, "status"); // busy must be clear by now
        bus_read(`ADDR_SCORE, got);
        compare(got, s.score, "score");
        for (int r = 0; r < 8; r++) begin
            bus_read(`ADDR_FRAME + 5'(r), got);
            compare(got, s.frame[r], $sformatf("frame row %0d", r));
        end
    endtask

    task automatic wait_done();
        while (!update_done) @(negedge clock);
        @(negedge clock);
        compare({7'b0, update_done}, 8'h00, "update_done one cycle after its pulse");
    endtask

    task automatic run_tick();
        expected = predict_tick(expected);
        bus_write(`ADDR_CTRL, 8'h01);
        wait_done();
        verify_state(expected);
    endtask

    initial begin
        game_state_t s;
        logic [7:0] got;
        void'($urandom(32'h8804_b7a4));
        wb_in = '0;
        reset = 1'b1;
        repeat (10) @(negedge clock);
        reset = 1'b0;

        expected = '0; // everything dark and idle after reset
        verify_state(expected);

        s = '0;
        s.shots[0] = make_obj(1'b1, 3, 6);
        s.ship_x = 3'd2;
        load_state(s);
        expected = s;
        repeat (4) run_tick(); // the shot leaves the grid in the last tick

        s = '0;
        s.shots[0] = make_obj(1'b1, 2, 5); // meets its asteroid after the first shot move
        s.asteroids[1] = make_obj(1'b1, 2, 4);
        s.shots[2] = make_obj(1'b1, 6, 7); // the asteroid falls onto this one
        s.asteroids[3] = make_obj(1'b1, 6, 4);
        load_state(s);
        expected = s;
        run_tick();

        s = '0;
        s.ship_x = 3'd5;
        s.asteroids[0] = make_obj(1'b1, 5, 6);
        s.asteroids[2] = make_obj(1'b1, 1, 6);
        load_state(s);
        expected = s;
        repeat (2) run_tick();

        s = '0;
        s.shots[1] = make_obj(1'b1, 4, 3);
        s.asteroids[0] = make_obj(1'b1, 4, 3); // collides in the first check, so the score is set
        s.asteroids[2] = make_obj(1'b1, 0, 1);
        s.ship_x = 3'd7;
        load_state(s);
        expected = predict_tick(s);
        bus_write(`ADDR_CTRL, 8'h01);
        bus_read(`ADDR_CTRL, got);
        compare(got, 8'h01, "status while busy");
        bus_write(5'd0, {1'b0, make_obj(1'b1, 7, 7)}); // host writes while busy are dropped
        bus_write(`ADDR_CTRL, 8'h01); // a restart here would clear the score again
        bus_write(`ADDR_SCORE, 8'h55);
        wait_done();
        verify_state(expected);

        for (int n = 0; n < RANDOM_SCENARIOS; n++) begin
            s = '0;
            for (int i = 0; i < `N_SHOTS; i++) begin
                s.shots[i] = random_obj(n[0]);
            end
            for (int i = 0; i < `N_ASTEROIDS; i++) begin
                s.asteroids[i] = random_obj(n[0]);
            end
            s.ship_x = coord_t'($urandom % 8);
            load_state(s);
            expected = s;
            repeat (TICKS_PER_SCENARIO) run_tick();
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
